// File: hdl/mario_world_pkg.sv
package mario_world_pkg;

    // ==================================================
    // Widths
    // ==================================================
    localparam int COORD_W = 10;
    localparam int SCORE_W = 24;

    // ==================================================
    // Screen and sprite boxes
    // ==================================================
    localparam logic [COORD_W-1:0] SCREEN_MAX_X = 10'd1023;
    // Top edge shared by standing players and the goomba
    localparam logic [COORD_W-1:0] GROUND_Y     = 10'd400;

    localparam logic [COORD_W-1:0] PLAYER_W     = 10'd26;
    localparam logic [COORD_W-1:0] PLAYER_H     = 10'd32;
    // Rightmost top-left x a player may reach
    localparam logic [COORD_W-1:0] PLAYER_MAX_X = SCREEN_MAX_X - PLAYER_W;

    localparam logic [COORD_W-1:0] GOMBA_W       = 10'd32;
    localparam logic [COORD_W-1:0] GOMBA_H       = 10'd32;
    localparam logic [COORD_W-1:0] GOMBA_MIN_X   = 10'd0;
    localparam logic [COORD_W-1:0] GOMBA_MAX_X   = SCREEN_MAX_X - GOMBA_W;
    localparam logic [COORD_W-1:0] GOMBA_START_X = 10'd400;

    // Coins
    localparam logic [COORD_W-1:0] COIN_W  = 10'd16;
    localparam logic [COORD_W-1:0] COIN_H  = 10'd28;
    localparam logic [COORD_W-1:0] COIN_Y  = 10'd340;
    localparam logic [COORD_W-1:0] COIN1_X = 10'd450;
    localparam logic [COORD_W-1:0] COIN2_X = 10'd900;

    // ==================================================
    // Physics, per frame
    // ==================================================
    localparam logic [COORD_W-1:0]        WALK_STEP    = 10'd2;
    localparam logic signed [COORD_W-1:0] JUMP_SPEED   = 10'sd10;
    localparam logic signed [COORD_W-1:0] GRAVITY      = 10'sd1;
    localparam logic [COORD_W-1:0]        STOMP_MARGIN = 10'd8;

    // USB HID key codes
    localparam logic [7:0] KEY_A     = 8'h04;
    localparam logic [7:0] KEY_D     = 8'h07;
    localparam logic [7:0] KEY_W     = 8'h1A;
    localparam logic [7:0] KEY_LEFT  = 8'h50;
    localparam logic [7:0] KEY_RIGHT = 8'h4F;
    localparam logic [7:0] KEY_UP    = 8'h52;

    localparam logic [COORD_W-1:0] MARIO_START_X = 10'd100;
    localparam logic [COORD_W-1:0] LUIGI_START_X = 10'd160;

    typedef enum logic [1:0] {
        ON_GROUND = 2'd0,
        IN_AIR    = 2'd1,
        DEAD      = 2'd2
    } player_state_t;

    // Strict overlap of two spans given by start and length
    function automatic logic spans_overlap(
        input logic [COORD_W-1:0] a,
        input logic [COORD_W-1:0] a_len,
        input logic [COORD_W-1:0] b,
        input logic [COORD_W-1:0] b_len
    );
        logic [COORD_W:0] a_end;
        logic [COORD_W:0] b_end;
        a_end = {1'b0, a} + {1'b0, a_len};
        b_end = {1'b0, b} + {1'b0, b_len};
        return ({1'b0, a} < b_end) && ({1'b0, b} < a_end);
    endfunction

endpackage

// File: hdl/player_if.sv
`timescale 1ns/1ps

interface player_if;
    import mario_world_pkg::*;

    // Top-left corner of the player box
    logic [COORD_W-1:0]        x;
    logic [COORD_W-1:0]        y;
    // Negative while rising
    logic signed [COORD_W-1:0] y_motion;
    logic                      alive;
    // Combinational level from the judge
    logic                      kill;

    modport mover (
        output x, y, y_motion, alive,
        input  kill
    );

    modport judge (
        input  x, y, y_motion, alive,
        output kill
    );

    // Coin pickup only looks at the box
    modport collector (
        input x, y, alive
    );

endinterface

// File: hdl/player_motion.sv
`timescale 1ns/1ps

module player_motion #(
    parameter logic [mario_world_pkg::COORD_W-1:0] START_X        = 10'd100,
    parameter logic [7:0]                          KEY_LEFT_CODE  = 8'h04,
    parameter logic [7:0]                          KEY_RIGHT_CODE = 8'h07,
    parameter logic [7:0]                          KEY_JUMP_CODE  = 8'h1A
) (
    input  logic           Clk,
    input  logic           rst_n,
    input  logic           frame_tick,
    input  logic [31:0]    keycode,
    player_if.mover        p
);
    import mario_world_pkg::*;

    player_state_t             state;
    logic [COORD_W-1:0]        x_q;
    logic [COORD_W-1:0]        y_q;
    logic signed [COORD_W-1:0] vy_q;

    logic                      left_held;
    logic                      right_held;
    logic                      jump_held;
    logic [COORD_W-1:0]        x_next;
    // Two extra bits so a step above the top or below ground is visible
    logic signed [COORD_W+1:0] y_sum;

    // Any of the four report bytes may carry the key
    function automatic logic key_down(input logic [31:0] codes, input logic [7:0] key);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (codes[8*i +: 8] == key) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    assign left_held  = key_down(keycode, KEY_LEFT_CODE);
    assign right_held = key_down(keycode, KEY_RIGHT_CODE);
    assign jump_held  = key_down(keycode, KEY_JUMP_CODE);

    // ==================================================
    // Horizontal step with left taking priority
    // ==================================================
    always_comb begin
        x_next = x_q;
        if (left_held) begin
            x_next = (x_q >= WALK_STEP) ? x_q - WALK_STEP : '0;
        end else if (right_held) begin
            x_next = (x_q <= PLAYER_MAX_X - WALK_STEP) ? x_q + WALK_STEP : PLAYER_MAX_X;
        end
    end

    // Candidate height for an airborne frame
    assign y_sum = $signed({2'b00, y_q}) + $signed({{2{vy_q[COORD_W-1]}}, vy_q});

    // ==================================================
    // Frame update
    // ==================================================
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            state <= ON_GROUND;
            x_q   <= START_X;
            y_q   <= GROUND_Y;
            vy_q  <= '0;
        end else if (frame_tick) begin
            if (state != DEAD && p.kill) begin
                // Killed players do not take this frame's step
                state <= DEAD;
            end else begin
                case (state)
                    ON_GROUND: begin
                        x_q <= x_next;
                        if (jump_held) begin
                            vy_q  <= -JUMP_SPEED;
                            state <= IN_AIR;
                        end
                    end
                    IN_AIR: begin
                        x_q <= x_next;
                        // Jump key ignored here
                        if (y_sum >= $signed({2'b00, GROUND_Y})) begin
                            y_q   <= GROUND_Y;
                            vy_q  <= '0;
                            state <= ON_GROUND;
                        end else if (y_sum < 0) begin
                            y_q  <= '0;
                            vy_q <= vy_q + GRAVITY;
                        end else begin
                            y_q  <= y_sum[COORD_W-1:0];
                            vy_q <= vy_q + GRAVITY;
                        end
                    end
                    default: begin
                        // Dead players stay frozen
                        state <= DEAD;
                    end
                endcase
            end
        end
    end

    assign p.x        = x_q;
    assign p.y        = y_q;
    assign p.y_motion = vy_q;
    assign p.alive    = (state != DEAD);

endmodule

// File: hdl/gomba_walker.sv
`timescale 1ns/1ps

module gomba_walker (
    input  logic                               Clk,
    input  logic                               rst_n,
    input  logic                               frame_tick,
    input  logic                               gomba_kill,
    output logic [mario_world_pkg::COORD_W-1:0] gomba_x,
    output logic                               gomba_alive
);
    import mario_world_pkg::*;

    logic [COORD_W-1:0] x_q;
    logic               alive_q;
    // High while walking right
    logic               dir_right;
    logic [COORD_W-1:0] x_next;

    // One pixel per frame
    assign x_next = dir_right ? x_q + COORD_W'(1) : x_q - COORD_W'(1);

    // ==================================================
    // Patrol between the two bounds
    // ==================================================
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            x_q       <= GOMBA_START_X;
            alive_q   <= 1'b1;
            dir_right <= 1'b1;
        end else if (frame_tick && alive_q) begin
            if (gomba_kill) begin
                // Freeze where it was stomped
                alive_q <= 1'b0;
            end else begin
                x_q <= x_next;
                // Turn around on reaching a bound
                if (dir_right && x_next >= GOMBA_MAX_X) begin
                    dir_right <= 1'b0;
                end else if (!dir_right && x_next <= GOMBA_MIN_X) begin
                    dir_right <= 1'b1;
                end
            end
        end
    end

    assign gomba_x     = x_q;
    assign gomba_alive = alive_q;

endmodule

// File: hdl/contact_judge.sv
`timescale 1ns/1ps

module contact_judge (
    player_if.judge                             mario,
    player_if.judge                             luigi,
    input  logic [mario_world_pkg::COORD_W-1:0] gomba_x,
    input  logic                                gomba_alive,
    output logic                                gomba_kill
);
    import mario_world_pkg::*;

    logic mario_touch;
    logic luigi_touch;
    logic mario_stomp;
    logic luigi_stomp;

    // Falling, and bottom no deeper than the margin into the goomba
    function automatic logic is_stomp(
        input logic [COORD_W-1:0]        py,
        input logic signed [COORD_W-1:0] vy
    );
        logic [COORD_W:0] bottom;
        logic [COORD_W:0] limit;
        bottom = {1'b0, py} + {1'b0, PLAYER_H};
        limit  = {1'b0, GROUND_Y} + {1'b0, STOMP_MARGIN};
        return (vy > 0) && (bottom <= limit);
    endfunction

    // ==================================================
    // Box overlap, goomba always at ground height
    // ==================================================
    assign mario_touch = mario.alive && gomba_alive
        && spans_overlap(mario.x, PLAYER_W, gomba_x, GOMBA_W)
        && spans_overlap(mario.y, PLAYER_H, GROUND_Y, GOMBA_H);

    assign luigi_touch = luigi.alive && gomba_alive
        && spans_overlap(luigi.x, PLAYER_W, gomba_x, GOMBA_W)
        && spans_overlap(luigi.y, PLAYER_H, GROUND_Y, GOMBA_H);

    assign mario_stomp = is_stomp(mario.y, mario.y_motion);
    assign luigi_stomp = is_stomp(luigi.y, luigi.y_motion);

    // Stomp kills the goomba
    assign gomba_kill = (mario_touch && mario_stomp) || (luigi_touch && luigi_stomp);

    // Any other contact is a side hit on the player
    assign mario.kill = mario_touch && !mario_stomp;
    assign luigi.kill = luigi_touch && !luigi_stomp;

endmodule

// File: hdl/coin_keeper.sv
`timescale 1ns/1ps

module coin_keeper (
    input  logic                                Clk,
    input  logic                                rst_n,
    input  logic                                frame_tick,
    player_if.collector                         mario,
    player_if.collector                         luigi,
    output logic [1:0]                          coin_alive,
    output logic [mario_world_pkg::SCORE_W-1:0] score
);
    import mario_world_pkg::*;

    logic [1:0]         alive_q;
    logic [SCORE_W-1:0] score_q;
    logic [1:0]         taken;
    logic [1:0]         taken_count;

    // Live player box against a coin at (cx, COIN_Y)
    function automatic logic grabs(
        input logic               p_alive,
        input logic [COORD_W-1:0] px,
        input logic [COORD_W-1:0] py,
        input logic [COORD_W-1:0] cx
    );
        return p_alive
            && spans_overlap(px, PLAYER_W, cx, COIN_W)
            && spans_overlap(py, PLAYER_H, COIN_Y, COIN_H);
    endfunction

    // ==================================================
    // Pickup detection
    // ==================================================
    assign taken[0] = alive_q[0] && (grabs(mario.alive, mario.x, mario.y, COIN1_X)
                                  || grabs(luigi.alive, luigi.x, luigi.y, COIN1_X));
    assign taken[1] = alive_q[1] && (grabs(mario.alive, mario.x, mario.y, COIN2_X)
                                  || grabs(luigi.alive, luigi.x, luigi.y, COIN2_X));

    // Both coins may go in the same frame
    assign taken_count = {1'b0, taken[0]} + {1'b0, taken[1]};

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            alive_q <= 2'b11;
            score_q <= '0;
        end else if (frame_tick) begin
            alive_q <= alive_q & ~taken;
            score_q <= score_q + {{(SCORE_W-2){1'b0}}, taken_count};
        end
    end

    assign coin_alive = alive_q;
    assign score      = score_q;

endmodule

// File: hdl/mario_world_top.sv
`timescale 1ns/1ps

module mario_world_top (
    input  logic                                Clk,
    input  logic                                rst_n,
    // One-cycle strobe per video frame
    input  logic                                frame_tick,
    input  logic [31:0]                         keycode,
    output logic [mario_world_pkg::COORD_W-1:0] mario_x,
    output logic [mario_world_pkg::COORD_W-1:0] mario_y,
    output logic [mario_world_pkg::COORD_W-1:0] luigi_x,
    output logic [mario_world_pkg::COORD_W-1:0] luigi_y,
    output logic [mario_world_pkg::COORD_W-1:0] gomba_x,
    output logic                                mario_alive,
    output logic                                luigi_alive,
    output logic                                gomba_alive,
    output logic [1:0]                          coin_alive,
    output logic [mario_world_pkg::SCORE_W-1:0] score
);
    import mario_world_pkg::*;

    // ==================================================
    // Player buses
    // ==================================================
    player_if mario_bus ();
    player_if luigi_bus ();

    logic gomba_kill;

    // Mario on WASD
    player_motion #(
        .START_X        (MARIO_START_X),
        .KEY_LEFT_CODE  (KEY_A),
        .KEY_RIGHT_CODE (KEY_D),
        .KEY_JUMP_CODE  (KEY_W)
    ) u_mario (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .frame_tick (frame_tick),
        .keycode    (keycode),
        .p          (mario_bus)
    );

    // Luigi on the arrow keys
    player_motion #(
        .START_X        (LUIGI_START_X),
        .KEY_LEFT_CODE  (KEY_LEFT),
        .KEY_RIGHT_CODE (KEY_RIGHT),
        .KEY_JUMP_CODE  (KEY_UP)
    ) u_luigi (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .frame_tick (frame_tick),
        .keycode    (keycode),
        .p          (luigi_bus)
    );

    gomba_walker u_gomba (
        .Clk         (Clk),
        .rst_n       (rst_n),
        .frame_tick  (frame_tick),
        .gomba_kill  (gomba_kill),
        .gomba_x     (gomba_x),
        .gomba_alive (gomba_alive)
    );

    // Kills are levels, sampled by the movers at the tick
    contact_judge u_judge (
        .mario       (mario_bus),
        .luigi       (luigi_bus),
        .gomba_x     (gomba_x),
        .gomba_alive (gomba_alive),
        .gomba_kill  (gomba_kill)
    );

    coin_keeper u_coins (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .frame_tick (frame_tick),
        .mario      (mario_bus),
        .luigi      (luigi_bus),
        .coin_alive (coin_alive),
        .score      (score)
    );

    // Player state out to the pins
    assign mario_x     = mario_bus.x;
    assign mario_y     = mario_bus.y;
    assign mario_alive = mario_bus.alive;
    assign luigi_x     = luigi_bus.x;
    assign luigi_y     = luigi_bus.y;
    assign luigi_alive = luigi_bus.alive;

endmodule

// File: testbench/mario_world_props.sv
`timescale 1ns/1ps

module mario_world_props (
    input logic                                Clk,
    input logic                                rst_n,
    input logic                                frame_tick,
    input mario_world_pkg::player_state_t      state,
    input logic [mario_world_pkg::COORD_W-1:0] x,
    input logic [mario_world_pkg::COORD_W-1:0] y
);
    import mario_world_pkg::*;

    // Death is final
    a_dead_sticks: assert property (@(posedge Clk) disable iff (!rst_n)
        state == DEAD |=> state == DEAD)
        else $error("player left the dead state");

    // Never below the ground line
    a_above_ground: assert property (@(posedge Clk) disable iff (!rst_n)
        y <= GROUND_Y)
        else $error("player y below ground line");

    // Frozen between frame ticks
    a_tick_only: assert property (@(posedge Clk) disable iff (!rst_n)
        ($past(rst_n) && !$past(frame_tick)) |-> ($stable(x) && $stable(y) && $stable(state)))
        else $error("player state changed without a frame tick");

endmodule

bind player_motion mario_world_props u_props (
    .Clk        (Clk),
    .rst_n      (rst_n),
    .frame_tick (frame_tick),
    .state      (state),
    .x          (x_q),
    .y          (y_q)
);

// File: testbench/mario_world_tb.sv
`timescale 1ns/1ps

module mario_world_tb;
    import mario_world_pkg::*;

    // ==================================================
    // Timing of the bench
    // ==================================================
    localparam int CLK_HALF      = 50;
    localparam int DRIVE_DELAY   = 10;
    localparam int RESET_CYCLES  = 16;
    localparam int FRAME_CYCLES  = 8;
    localparam int RESET_TIMEOUT = 64;

    logic                Clk;
    logic                rst_n;
    logic                frame_tick;
    logic [31:0]         keycode;

    logic [COORD_W-1:0]  mario_x;
    logic [COORD_W-1:0]  mario_y;
    logic [COORD_W-1:0]  luigi_x;
    logic [COORD_W-1:0]  luigi_y;
    logic [COORD_W-1:0]  gomba_x;
    logic                mario_alive;
    logic                luigi_alive;
    logic                gomba_alive;
    logic [1:0]          coin_alive;
    logic [SCORE_W-1:0]  score;

    // Bookkeeping
    int                  errors;
    int                  checks;
    int                  tests_run;
    int                  tests_bad;
    bit                  test_bad;
    int                  phase;
    logic [78:0]         snapshot;

    mario_world_top UUT (
        .Clk         (Clk),
        .rst_n       (rst_n),
        .frame_tick  (frame_tick),
        .keycode     (keycode),
        .mario_x     (mario_x),
        .mario_y     (mario_y),
        .luigi_x     (luigi_x),
        .luigi_y     (luigi_y),
        .gomba_x     (gomba_x),
        .mario_alive (mario_alive),
        .luigi_alive (luigi_alive),
        .gomba_alive (gomba_alive),
        .coin_alive  (coin_alive),
        .score       (score)
    );

    // 100 ns clock
    initial begin
        Clk = 1'b0;
        forever #CLK_HALF Clk = ~Clk;
    end

    // All outputs in one word for the between-tick check
    function automatic logic [78:0] output_word();
        return {mario_x, mario_y, luigi_x, luigi_y, gomba_x,
                mario_alive, luigi_alive, gomba_alive, coin_alive, score};
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            $display("MISMATCH at %0t ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    // Inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge Clk);
        #DRIVE_DELAY;
    endtask

    // ==================================================
    // Frame strobes, one every 8 cycles
    // ==================================================
    task automatic run_frames(input int count, output bit timed_out);
        int frames_done;
        int cycles;
        frames_done = 0;
        cycles      = 0;
        timed_out   = 1'b0;
        while (frames_done < count && !timed_out) begin
            next_cycle();
            cycles++;
            if (phase == FRAME_CYCLES - 1) begin
                frame_tick = 1'b1;
                phase      = 0;
            end else begin
                if (frame_tick) begin
                    // Tick edge has passed, outputs settle here
                    frame_tick = 1'b0;
                    snapshot   = output_word();
                    frames_done++;
                end else if (output_word() !== snapshot) begin
                    $display("Outputs changed between frame ticks at %0t ns", $time);
                    errors++;
                    test_bad = 1'b1;
                    snapshot = output_word();
                end
                phase++;
            end
            if (cycles > count * FRAME_CYCLES + FRAME_CYCLES) begin
                timed_out = 1'b1;
            end
        end
    endtask

    // One line per finished test
    task automatic finish_test(input int id);
        if (id >= 0) begin
            tests_run++;
            if (test_bad) begin
                tests_bad++;
            end
            $display("test %0d %s", id, test_bad ? "FAIL" : "ok");
            test_bad = 1'b0;
        end
    endtask

    // ==================================================
    // Vector replay
    // ==================================================
    initial begin
        int          fd;
        int          n;
        string       line;
        int          test_id;
        int          frames;
        logic [31:0] key;
        int          e_mx, e_my, e_lx, e_ly, e_gx;
        int          e_ma, e_la, e_ga, e_coin, e_score;
        int          current_test;
        int          wait_cycles;
        bit          timed_out;
        bit          aborted;

        rst_n      = 1'b0;
        frame_tick = 1'b0;
        keycode    = '0;
        errors     = 0;
        checks     = 0;
        tests_run  = 0;
        tests_bad  = 0;
        test_bad   = 1'b0;
        phase      = 0;
        aborted    = 1'b0;
        snapshot   = '0;

        repeat (RESET_CYCLES) next_cycle();
        rst_n = 1'b1;

        // Start state must show up after release
        wait_cycles = 0;
        while (!aborted && !(mario_alive && luigi_alive && gomba_alive
                             && coin_alive == 2'b11)) begin
            next_cycle();
            wait_cycles++;
            if (wait_cycles > RESET_TIMEOUT) begin
                $display("Start state never appeared after reset release");
                aborted = 1'b1;
            end
        end
        snapshot = output_word();

        fd = $fopen("testbench/mario_world_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file");
            aborted = 1'b1;
        end else begin
            current_test = -1;
            while (!aborted && !$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %d %h %d %d %d %d %d %d %d %d %d %d",
                                test_id, frames, key, e_mx, e_my, e_lx, e_ly, e_gx,
                                e_ma, e_la, e_ga, e_coin, e_score);
                    if (n == 13) begin
                        if (test_id != current_test) begin
                            finish_test(current_test);
                            current_test = test_id;
                        end
                        keycode = key;
                        run_frames(frames, timed_out);
                        if (timed_out) begin
                            $display("Frame loop timed out in test %0d", test_id);
                            aborted = 1'b1;
                        end else begin
                            // State after the last frame of the line
                            check_value("mario_x", e_mx, int'(mario_x));
                            check_value("mario_y", e_my, int'(mario_y));
                            check_value("luigi_x", e_lx, int'(luigi_x));
                            check_value("luigi_y", e_ly, int'(luigi_y));
                            check_value("gomba_x", e_gx, int'(gomba_x));
                            check_value("mario_alive", e_ma, int'(mario_alive));
                            check_value("luigi_alive", e_la, int'(luigi_alive));
                            check_value("gomba_alive", e_ga, int'(gomba_alive));
                            check_value("coin_alive", e_coin, int'(coin_alive));
                            check_value("score", e_score, int'(score));
                        end
                    end
                end
            end
            finish_test(current_test);
            $fclose(fd);
        end

        $display("%0d tests run, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (!aborted && errors == 0 && tests_run > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: testbench/mario_world_vectors.txt
# test frames keycode(hex) mario_x mario_y luigi_x luigi_y gomba_x
# mario_alive luigi_alive gomba_alive coin_alive score (decimal, after the last frame)
1 10 00000007 120 400 160 400 410 1 1 1 3 0
1 5 0000504F 120 400 150 400 415 1 1 1 3 0
2 1 0000001A 120 400 150 400 416 1 1 1 3 0
2 5 0000001A 120 360 150 400 421 1 1 1 3 0
2 5 00000000 120 345 150 400 426 1 1 1 3 0
2 11 00000000 120 400 150 400 437 1 1 1 3 0
3 3 00000000 120 400 150 400 440 1 1 1 3 0
4 150 00000007 420 400 150 400 590 1 1 1 3 0
4 1 00001A07 422 400 150 400 591 1 1 1 3 0
4 4 00000007 430 366 150 400 595 1 1 1 3 0
4 1 00000007 432 360 150 400 596 1 1 1 2 1
4 16 00000000 432 400 150 400 612 1 1 1 2 1
6 155 00000007 742 400 150 400 767 1 1 1 2 1
6 1 00000007 742 400 150 400 768 0 1 1 2 1
6 5 00001A07 742 400 150 400 773 0 1 1 2 1
5 100 0000004F 742 400 350 400 873 0 1 1 2 1
5 715 00000000 742 400 350 400 394 0 1 1 2 1
5 1 00000052 742 400 350 400 393 0 1 1 2 1
5 17 00000000 742 400 350 366 376 0 1 1 2 1
5 1 00000000 742 400 350 373 375 0 1 1 2 1
5 1 00000000 742 400 350 381 375 0 1 0 2 1
5 2 00000000 742 400 350 400 375 0 1 0 2 1

// File: mario_world_top.f
hdl/mario_world_pkg.sv
hdl/player_if.sv
hdl/player_motion.sv
hdl/gomba_walker.sv
hdl/contact_judge.sv
hdl/coin_keeper.sv
hdl/mario_world_top.sv
testbench/mario_world_props.sv
testbench/mario_world_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f mario_world_top.f \
    --top-module mario_world_tb \
    -o mario_world_sim

output=$(./obj_dir/mario_world_sim)
echo "$output"

if echo "$output" | grep -q "all tests passed"; then
    exit 0
else
    exit 1
fi
